//--- src/dii_pkg.sv
`default_nettype none

package dii_pkg;

  // Debug flit payload.
  localparam int FLIT_W = 16;
  typedef logic [FLIT_W-1:0] flit_data_t;

  // Request header layout: we, burst, beat count in the low bits.
  localparam int HDR_WE_BIT    = 15; // Set for write requests.
  localparam int HDR_BURST_BIT = 14; // Clear means single access.
  localparam int HDR_BEATS_W   = 13; // Beat count field width.

  // Response header.
  // Kind code sits in bit 15, payload below it.
  localparam logic RESP_KIND_READ = 1'b0; // Read header, beat count follows.
  localparam logic RESP_KIND_ACK  = 1'b1; // Write acknowledge, id bits follow.

  // Id bits carried in the ack flit.
  localparam int RESP_ID_W = 14;

endpackage

`default_nettype wire

//--- src/mam_pkg.sv
`default_nettype none

package mam_pkg;

  // Memory side.
  localparam int ADDR_FLITS = 2; // Address flits per request, high half first.
  localparam int MEM_ADDR_W = dii_pkg::FLIT_W * ADDR_FLITS;
  localparam int MEM_DATA_W = 16; // One word per beat.

  typedef logic [MEM_ADDR_W-1:0] mem_addr_t; // Word address.
  typedef logic [MEM_DATA_W-1:0] mem_data_t; // RAM word.

  // Beat count, same width as the header field.
  typedef logic [dii_pkg::HDR_BEATS_W-1:0] beats_t;

  // Controller states.
  typedef enum logic [2:0] {
    IDLE,     // Waiting for a header flit.
    ADDR_HI,  // Upper address half.
    ADDR_LO,  // Lower address half.
    WR_DATA,  // One data flit per beat.
    RD_ISSUE, // Read strobe to the RAM port.
    RD_WAIT,  // RAM enable cycle.
    RD_SEND,  // Load and hand out the read word.
    ACK_SEND  // Write acknowledge out.
  } mam_state_t;

endpackage

`default_nettype wire

//--- src/mam_ctrl_fsm.sv
`default_nettype none
`timescale 1ns/1ps

module mam_ctrl_fsm
  import mam_pkg::*;
(
  input  wire  clk_i,
  input  wire  arst_n_i,

  input  wire  in_valid_i,      // Incoming flit present.
  output logic in_ready_o,      // Flit accepted in input states only.
  input  wire  out_done_i,      // Response slot is empty.
  input  wire  hdr_we_i,        // Captured write flag.
  input  wire  last_beat_i,     // One beat left.

  output logic hdr_load_o,
  output logic addr_hi_load_o,
  output logic addr_lo_load_o,
  output logic addr_step_o,
  output logic cnt_load_o,
  output logic cnt_dec_o,
  output logic wr_stb_o,
  output logic rd_stb_o,
  output logic rd_capture_o,
  output logic send_hdr_o,
  output logic send_data_o,
  output logic send_ack_o
);

  mam_state_t state_q, state_d;
  logic       loaded_q;   // Flit of the current send state already handed over.
  logic       loaded_d;
  logic       accept;     // Flit transfer this cycle.

  assign accept = in_valid_i & in_ready_o;

  always_comb begin
    state_d        = state_q;
    hdr_load_o     = 1'b0;
    addr_hi_load_o = 1'b0;
    addr_lo_load_o = 1'b0;
    addr_step_o    = 1'b0;
    cnt_load_o     = 1'b0;
    cnt_dec_o      = 1'b0;
    wr_stb_o       = 1'b0;
    rd_stb_o       = 1'b0;
    rd_capture_o   = 1'b0;
    send_hdr_o     = 1'b0;
    send_data_o    = 1'b0;
    send_ack_o     = 1'b0;

    case (state_q)
      IDLE: begin
        if (accept) begin
          hdr_load_o = 1'b1;
          state_d    = ADDR_HI;
        end
      end
      ADDR_HI: begin
        if (accept) begin
          addr_hi_load_o = 1'b1;
          cnt_load_o     = 1'b1; // Beat count already held by the capture.
          state_d        = ADDR_LO;
        end
      end
      ADDR_LO: begin
        if (accept) begin
          addr_lo_load_o = 1'b1;
          if (hdr_we_i) begin
            state_d = WR_DATA;
          end else begin
            send_hdr_o = 1'b1; // Slot is free, previous packet fully drained.
            state_d    = RD_ISSUE;
          end
        end
      end
      WR_DATA: begin
        // Each data flit becomes one RAM write at the current address.
        if (accept) begin
          wr_stb_o    = 1'b1;
          addr_step_o = 1'b1;
          cnt_dec_o   = 1'b1;
          if (last_beat_i) state_d = ACK_SEND;
        end
      end
      RD_ISSUE: begin
        rd_stb_o    = 1'b1;
        addr_step_o = 1'b1; // Port has registered the old address.
        state_d     = RD_WAIT;
      end
      RD_WAIT: begin
        rd_capture_o = 1'b1; // Enable cycle, word shows up next cycle.
        state_d      = RD_SEND;
      end
      RD_SEND: begin
        if (!loaded_q) begin
          if (out_done_i) send_data_o = 1'b1; // Header or previous word gone.
        end else if (out_done_i) begin
          cnt_dec_o = 1'b1;
          state_d   = last_beat_i ? IDLE : RD_ISSUE;
        end
      end
      ACK_SEND: begin
        // Entered in the write cycle, so the ack comes one cycle later.
        if (!loaded_q) begin
          if (out_done_i) send_ack_o = 1'b1;
        end else if (out_done_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // Cleared on every state change.
  assign loaded_d = (state_d == state_q) & (loaded_q | send_data_o | send_ack_o);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= IDLE;
      loaded_q   <= 1'b0;
      in_ready_o <= 1'b0; // Low through reset, high one cycle after release.
    end else begin
      state_q    <= state_d;
      loaded_q   <= loaded_d;
      in_ready_o <= (state_d inside {IDLE, ADDR_HI, ADDR_LO, WR_DATA});
    end
  end

endmodule

`default_nettype wire

//--- src/mam_beat_counter.sv
`default_nettype none
`timescale 1ns/1ps

module mam_beat_counter
  import mam_pkg::*;
(
  input  wire    clk_i,
  input  wire    arst_n_i,
  input  wire    cnt_load_i,  // Start of a transfer.
  input  wire    cnt_dec_i,   // One beat completed.
  input  wire    beats_t beats_i,
  output logic   last_beat_o  // Level, one beat remaining.
);

  beats_t cnt_q; // Beats still to do.

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (cnt_load_i) begin
      cnt_q <= beats_i;
    end else if (cnt_dec_i && cnt_q != '0) begin
      cnt_q <= cnt_q - beats_t'(1); // Saturates at zero.
    end
  end

  // Same level serves both the write and the read loop.
  assign last_beat_o = (cnt_q == beats_t'(1));

endmodule

`default_nettype wire

//--- src/mam_req_capture.sv
`default_nettype none
`timescale 1ns/1ps

module mam_req_capture
  import dii_pkg::*;
  import mam_pkg::*;
(
  input  wire             clk_i,
  input  wire             arst_n_i,
  input  wire flit_data_t flit_i,         // Incoming request flit.
  input  wire             hdr_load_i,     // Header flit accepted.
  input  wire             addr_hi_load_i, // Upper address half.
  input  wire             addr_lo_load_i, // Lower address half.
  input  wire             addr_step_i,    // Next word.
  output logic            hdr_we_o,
  output beats_t          beats_o,
  output mem_addr_t       addr_o
);

  beats_t hdr_beats; // Count decoded from the header flit.

  // Single access ignores the count field.
  assign hdr_beats = flit_i[HDR_BURST_BIT] ? flit_i[HDR_BEATS_W-1:0] : beats_t'(1);

  // Header fields.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hdr_we_o <= 1'b0;
      beats_o  <= '0;
    end else if (hdr_load_i) begin
      hdr_we_o <= flit_i[HDR_WE_BIT];
      beats_o  <= hdr_beats;
    end
  end

  // Word address, high half arrives first.
  always_ff @(posedge clk_i) begin
    if (addr_hi_load_i) begin
      addr_o[MEM_ADDR_W-1 -: FLIT_W] <= flit_i;
    end else if (addr_lo_load_i) begin
      addr_o[FLIT_W-1:0] <= flit_i;
    end else if (addr_step_i) begin
      addr_o <= addr_o + mem_addr_t'(1); // One word per beat.
    end
  end

endmodule

`default_nettype wire

//--- src/mam_bram_port.sv
`default_nettype none
`timescale 1ns/1ps

module mam_bram_port
  import mam_pkg::*;
(
  input  wire            clk_i,
  input  wire            arst_n_i,
  input  wire            wr_stb_i,  // Write one word.
  input  wire            rd_stb_i,  // Read one word.
  input  wire mem_addr_t addr_i,
  input  wire mem_data_t wdata_i,
  output mem_addr_t      addr_o,
  output mem_data_t      din_o,
  output logic           en_o,
  output logic           we_o
);

  // Enables, one pulse per strobe.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      en_o <= 1'b0;
      we_o <= 1'b0;
    end else begin
      en_o <= wr_stb_i | rd_stb_i;
      we_o <= wr_stb_i; // Low for reads and idle cycles.
    end
  end

  // Address and data, held between accesses.
  always_ff @(posedge clk_i) begin
    if (wr_stb_i || rd_stb_i) begin
      addr_o <= addr_i;
    end
    if (wr_stb_i) begin
      din_o <= wdata_i;
    end
  end

endmodule

`default_nettype wire

//--- src/mam_resp_builder.sv
`default_nettype none
`timescale 1ns/1ps

module mam_resp_builder
  import dii_pkg::*;
  import mam_pkg::*;
(
  input  wire              clk_i,
  input  wire              arst_n_i,
  input  wire              send_hdr_i,   // Load read header.
  input  wire              send_data_i,  // Load captured word.
  input  wire              send_ack_i,   // Load write ack.
  input  wire              rd_capture_i, // RAM enable cycle of a read.
  input  wire beats_t      beats_i,
  input  wire [FLIT_W-1:0] id_i,
  input  wire              last_beat_i,
  input  wire mem_data_t   dout_i,
  output flit_data_t       out_data_o,
  output logic             out_last_o,
  output logic             out_valid_o,
  input  wire              out_ready_i,
  output logic             out_done_o    // Nothing held, nothing in flight.
);

  logic      cap_q;   // Read word arrives this cycle.
  mem_data_t rd_word; // Last word read.

  // Word is valid one cycle after the enable.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cap_q <= 1'b0;
    end else begin
      cap_q <= rd_capture_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cap_q) rd_word <= dout_i;
  end

  // Output flit slot.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_valid_o <= 1'b0;
      out_last_o  <= 1'b0;
      out_data_o  <= '0;
    end else if (send_hdr_i) begin
      out_valid_o <= 1'b1;
      out_last_o  <= 1'b0; // Data flits follow.
      out_data_o  <= {RESP_KIND_READ, {(FLIT_W-1-HDR_BEATS_W){1'b0}}, beats_i};
    end else if (send_data_i) begin
      out_valid_o <= 1'b1;
      out_last_o  <= last_beat_i;
      out_data_o  <= rd_word;
    end else if (send_ack_i) begin
      out_valid_o <= 1'b1;
      out_last_o  <= 1'b1;
      out_data_o  <= {RESP_KIND_ACK, {(FLIT_W-1-RESP_ID_W){1'b0}}, id_i[RESP_ID_W-1:0]};
    end else if (out_valid_o && out_ready_i) begin
      out_valid_o <= 1'b0; // Data and last stay put.
    end
  end

  // Includes a pending capture so a send never takes a stale word.
  assign out_done_o = ~out_valid_o & ~cap_q;

endmodule

`default_nettype wire

//--- src/mam_top.sv
`default_nettype none
`timescale 1ns/1ps

module mam_top
  import dii_pkg::*;
  import mam_pkg::*;
(
  input  wire              clk_i,
  input  wire              arst_n_i,

  // Request flits.
  input  wire flit_data_t  debug_in_data_i,
  input  wire              debug_in_last_i,  // Framing follows from the beat count.
  input  wire              debug_in_valid_i,
  output logic             debug_in_ready_o,

  // Response flits.
  output flit_data_t       debug_out_data_o,
  output logic             debug_out_last_o,
  output logic             debug_out_valid_o,
  input  wire              debug_out_ready_i,

  input  wire [FLIT_W-1:0] id_i,             // Static block id.

  // Block RAM port.
  output mem_addr_t        addr_o,
  output mem_data_t        din_o,
  output logic             en_o,
  output logic             we_o,
  input  wire mem_data_t   dout_i
);

  logic      hdr_load, addr_hi_load, addr_lo_load, addr_step;
  logic      cnt_load, cnt_dec, last_beat;
  logic      wr_stb, rd_stb, rd_capture;
  logic      send_hdr, send_data, send_ack, out_done;
  logic      hdr_we;
  beats_t    beats;
  mem_addr_t req_addr;

  mam_ctrl_fsm u_ctrl_fsm (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .in_valid_i     (debug_in_valid_i),
    .in_ready_o     (debug_in_ready_o),
    .out_done_i     (out_done),
    .hdr_we_i       (hdr_we),
    .last_beat_i    (last_beat),
    .hdr_load_o     (hdr_load),
    .addr_hi_load_o (addr_hi_load),
    .addr_lo_load_o (addr_lo_load),
    .addr_step_o    (addr_step),
    .cnt_load_o     (cnt_load),
    .cnt_dec_o      (cnt_dec),
    .wr_stb_o       (wr_stb),
    .rd_stb_o       (rd_stb),
    .rd_capture_o   (rd_capture),
    .send_hdr_o     (send_hdr),
    .send_data_o    (send_data),
    .send_ack_o     (send_ack)
  );

  mam_beat_counter u_beat_counter (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .cnt_load_i  (cnt_load),
    .cnt_dec_i   (cnt_dec),
    .beats_i     (beats),
    .last_beat_o (last_beat)
  );

  mam_req_capture u_req_capture (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .flit_i         (debug_in_data_i),
    .hdr_load_i     (hdr_load),
    .addr_hi_load_i (addr_hi_load),
    .addr_lo_load_i (addr_lo_load),
    .addr_step_i    (addr_step),
    .hdr_we_o       (hdr_we),
    .beats_o        (beats),
    .addr_o         (req_addr)
  );

  // Write data comes straight from the accepted flit.
  mam_bram_port u_bram_port (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .wr_stb_i (wr_stb),
    .rd_stb_i (rd_stb),
    .addr_i   (req_addr),
    .wdata_i  (debug_in_data_i),
    .addr_o   (addr_o),
    .din_o    (din_o),
    .en_o     (en_o),
    .we_o     (we_o)
  );

  mam_resp_builder u_resp_builder (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .send_hdr_i   (send_hdr),
    .send_data_i  (send_data),
    .send_ack_i   (send_ack),
    .rd_capture_i (rd_capture),
    .beats_i      (beats),
    .id_i         (id_i),
    .last_beat_i  (last_beat),
    .dout_i       (dout_i),
    .out_data_o   (debug_out_data_o),
    .out_last_o   (debug_out_last_o),
    .out_valid_o  (debug_out_valid_o),
    .out_ready_i  (debug_out_ready_i),
    .out_done_o   (out_done)
  );

endmodule

`default_nettype wire

//--- dv/mam_asserts.sv
`default_nettype none
`timescale 1ns/1ps

module mam_asserts
  import dii_pkg::*;
  import mam_pkg::*;
(
  input wire             clk_i,
  input wire             arst_n_i,
  input wire flit_data_t debug_out_data_o,
  input wire             debug_out_last_o,
  input wire             debug_out_valid_o,
  input wire             debug_out_ready_i,
  input wire             debug_in_ready_o,
  input wire             en_o,
  input wire             we_o
);

  int unsigned fail_count = 0; // Read by the testbench.

  // Held flit must not change or drop until it transfers.
  property out_flit_held;
    @(posedge clk_i) disable iff (!arst_n_i)
      (debug_out_valid_o && !debug_out_ready_i) |=>
        (debug_out_valid_o && $stable(debug_out_data_o) && $stable(debug_out_last_o));
  endproperty

  // No handshake or RAM activity while in reset.
  property quiet_in_reset;
    @(posedge clk_i)
      !arst_n_i |-> (!en_o && !we_o && !debug_out_valid_o && !debug_in_ready_o);
  endproperty

  property we_needs_en;
    @(posedge clk_i) disable iff (!arst_n_i) we_o |-> en_o;
  endproperty

  held_flit_a: assert property (out_flit_held)
    else begin
      fail_count++;
      $error("Outgoing flit changed or dropped while stalled.");
    end

  reset_quiet_a: assert property (quiet_in_reset)
    else begin
      fail_count++;
      $error("Control output active during reset.");
    end

  we_en_a: assert property (we_needs_en)
    else begin
      fail_count++;
      $error("we_o high without en_o.");
    end

endmodule

`default_nettype wire

//--- dv/mam_tb.sv
`default_nettype none
`timescale 1ns/1ps

module mam_tb
  import dii_pkg::*;
  import mam_pkg::*;
;

  localparam logic [15:0] ID        = 16'hc3a5;
  localparam int          RAND_PKTS = 16; // Random packets, up to 8 beats each.
  localparam int          TOTAL_BEATS = 1 + 8 + 8 + 6 + RAND_PKTS * 8;
  localparam int          TIMEOUT_CYCLES = TOTAL_BEATS * 20 + 980; // Twenty per beat.

  logic       clk_i, arst_n_i;
  flit_data_t debug_in_data_i, debug_out_data_o;
  logic       debug_in_last_i, debug_in_valid_i, debug_in_ready_o;
  logic       debug_out_last_o, debug_out_valid_o, debug_out_ready_i;
  logic [15:0] id_i;
  mem_addr_t  addr_o;
  mem_data_t  din_o, dout_i;
  logic       en_o, we_o;

  mem_data_t   ram [256];      // RAM model.
  mem_data_t   ref_mem [256];  // Expected contents.
  logic [16:0] exp_q [$];      // Expected response flits, {last, data}.
  integer      data_seed  = 32'h6f3ea7e5;
  integer      stall_seed = 32'h6f3ea7e5 ^ 32'h1;
  logic        gaps_on, stalls_on;
  int          wr_seen, cycles;

  mam_top mam_top_i (.*);

  bind mam_top mam_asserts u_asserts (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .debug_out_data_o  (debug_out_data_o),
    .debug_out_last_o  (debug_out_last_o),
    .debug_out_valid_o (debug_out_valid_o),
    .debug_out_ready_i (debug_out_ready_i),
    .debug_in_ready_o  (debug_in_ready_o),
    .en_o              (en_o),
    .we_o              (we_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "Run stopped at first error.");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
      else stop_with_failure($sformatf("** Error: %s expected %h got %h", name, exp, act));
  endtask

  // Synchronous RAM, one cycle read latency.
  always @(posedge clk_i) begin
    if (en_o && we_o) ram[addr_o[7:0]] <= din_o;
    if (en_o && !we_o) dout_i <= ram[addr_o[7:0]];
  end

  // Response checker, stall driver, write counter and timeout.
  always @(negedge clk_i) begin
    debug_out_ready_i = 1'($random(stall_seed)) | ~stalls_on; // Bit 0 only.
    if (debug_out_valid_o && debug_out_ready_i) begin // Transfers at next posedge.
      if (exp_q.size() == 0) begin
        stop_with_failure("Response flit arrived with none expected.");
      end else begin
        check_value("debug_out_last_o", exp_q[0][16], debug_out_last_o);
        check_value("debug_out_data_o", exp_q[0][15:0], debug_out_data_o);
        void'(exp_q.pop_front());
      end
    end
    if (en_o && we_o) wr_seen++;
    if (mam_top_i.u_asserts.fail_count != 0) begin
      stop_with_failure("A bound assertion on the DUT ports failed.");
    end
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      stop_with_failure($sformatf("Timeout after %0d cycles.", TIMEOUT_CYCLES));
    end
  end

  // Called at a falling edge, returns at the falling edge after the transfer.
  task automatic send_flit(input flit_data_t data, input logic last);
    while (gaps_on && ($random(data_seed) & 3) == 0) begin
      debug_in_valid_i = 1'b0;
      @(negedge clk_i);
    end
    debug_in_data_i  = data;
    debug_in_last_i  = last;
    debug_in_valid_i = 1'b1;
    while (!debug_in_ready_o) @(negedge clk_i);
    @(negedge clk_i);
    debug_in_valid_i = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) @(negedge clk_i);
    repeat (2) @(negedge clk_i); // Catches any extra flit.
  endtask

  task automatic write_burst(input mem_addr_t addr, input int n, input logic burst);
    flit_data_t hdr;
    mem_data_t  d;
    mem_addr_t  a;
    int         wr_before;
    hdr                    = '0;
    hdr[HDR_WE_BIT]        = 1'b1;
    hdr[HDR_BURST_BIT]     = burst;
    hdr[HDR_BEATS_W-1:0]   = beats_t'(n);
    wr_before              = wr_seen;
    exp_q.push_back({1'b1, RESP_KIND_ACK, 1'b0, ID[13:0]}); // Ack flit.
    send_flit(hdr, 1'b0);
    send_flit(addr[31:16], 1'b0);
    send_flit(addr[15:0], 1'b0);
    for (int i = 0; i < n; i++) begin
      d = mem_data_t'($random(data_seed));
      a = addr + mem_addr_t'(i);
      send_flit(d, i == n - 1);
      check_value("en_o", 1, en_o); // One cycle after the data flit.
      check_value("we_o", 1, we_o);
      check_value("addr_o", a, addr_o);
      check_value("din_o", d, din_o);
      ref_mem[a[7:0]] = d;
    end
    wait_drained();
    check_value("write cycle count", n, wr_seen - wr_before);
  endtask

  task automatic read_burst(input mem_addr_t addr, input int n, input logic burst);
    flit_data_t hdr;
    mem_addr_t  a;
    hdr                  = '0;
    hdr[HDR_BURST_BIT]   = burst;
    hdr[HDR_BEATS_W-1:0] = beats_t'(n);
    exp_q.push_back({1'b0, RESP_KIND_READ, 2'b00, beats_t'(n)});
    for (int i = 0; i < n; i++) begin
      a = addr + mem_addr_t'(i);
      exp_q.push_back({i == n - 1, ref_mem[a[7:0]]});
    end
    send_flit(hdr, 1'b0);
    send_flit(addr[31:16], 1'b0);
    send_flit(addr[15:0], 1'b1);
    wait_drained();
  endtask

  initial begin
    mem_addr_t addr;
    int        n;
    int        r;
    arst_n_i          = 1'b0;
    debug_in_data_i   = '0;
    debug_in_last_i   = 1'b0;
    debug_in_valid_i  = 1'b0;
    debug_out_ready_i = 1'b1;
    id_i              = ID; // Static block id.
    dout_i            = '0;
    gaps_on           = 1'b0;
    stalls_on         = 1'b0;
    wr_seen           = 0;
    cycles            = 0;
    for (int i = 0; i < 256; i++) begin
      ram[i]     = mem_data_t'(i) ^ 16'h5a5a;
      ref_mem[i] = mem_data_t'(i) ^ 16'h5a5a;
    end

    repeat (4) @(negedge clk_i);
    check_value("en_o", 0, en_o);
    check_value("debug_out_valid_o", 0, debug_out_valid_o);
    arst_n_i = 1'b1;
    check_value("debug_in_ready_o", 0, debug_in_ready_o);
    @(negedge clk_i);
    check_value("debug_in_ready_o", 1, debug_in_ready_o); // IDLE reached.
    check_value("en_o", 0, en_o);
    check_value("we_o", 0, we_o);
    check_value("debug_out_valid_o", 0, debug_out_valid_o);

    write_burst(32'h10, 1, 1'b0);
    write_burst(32'h20, 8, 1'b1);
    read_burst(32'h20, 8, 1'b1); // New contents back.
    read_burst(32'h40, 6, 1'b1);

    gaps_on   = 1'b1;
    stalls_on = 1'b1;
    for (int k = 0; k < RAND_PKTS; k++) begin
      addr = mem_addr_t'($random(data_seed));
      r    = $random(data_seed);
      n    = 1 + (r & 7);
      if (r[3]) write_burst(addr, n, (n != 1) || r[4]);
      else read_burst(addr, n, (n != 1) || r[4]);
    end

    if (mam_top_i.u_asserts.fail_count != 0) begin
      stop_with_failure("A bound assertion on the DUT ports failed.");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- filelist.f
src/dii_pkg.sv
src/mam_pkg.sv
src/mam_ctrl_fsm.sv
src/mam_beat_counter.sv
src/mam_req_capture.sv
src/mam_bram_port.sv
src/mam_resp_builder.sv
src/mam_top.sv
dv/mam_asserts.sv
dv/mam_tb.sv
